//--- design/timer_map_pkg.sv
`default_nettype none

// ----------------------------------------
// Register map of the timer peripheral
// ----------------------------------------
package timer_map_pkg;

	localparam int ADDR_W = 4;						// Register address width

	localparam logic [ADDR_W-1:0] ADDR_TCCR  = 4'd1;	// Control
	localparam logic [ADDR_W-1:0] ADDR_TCCR2 = 4'd2;	// Control 2
	localparam logic [ADDR_W-1:0] ADDR_TCNT  = 4'd3;	// Count value
	localparam logic [ADDR_W-1:0] ADDR_OCR   = 4'd4;	// Output compare
	localparam logic [ADDR_W-1:0] ADDR_TCST  = 4'd6;	// Status

	// TCCR bit positions
	localparam int TCCR_GEN      = 0;					// Global enable
	localparam int TCCR_GIE      = 1;					// Global interrupt enable
	localparam int TCCR_OVIE     = 2;					// Overflow irq enable
	localparam int TCCR_CMIE     = 3;					// Compare irq enable
	localparam int TCCR_PWIE     = 4;					// PWM irq enable
	localparam int TCCR_CNTEN    = 6;					// Counting enable
	localparam int TCCR_WMOD_LSB = 8;					// Waveform mode, 2 bits
	localparam int TCCR_PINEN    = 10;					// Output pin enable
	localparam int TCCR_PINPOL   = 11;					// Output pin polarity

	// TCCR2 fields, given as LSB positions
	localparam int TCCR2_PRS    = 0;					// Prescale value
	localparam int TCCR2_TOPSEL = 8;					// TOP select
	localparam int TCCR2_CMPSEL = 12;					// COMPARE select
	localparam int PRS_W        = 8;					// Prescale field width
	localparam int SEL_W        = 4;					// Select field width

	// TCST bit positions
	localparam int TCST_OVF = 0;						// Overflow
	localparam int TCST_CMP = 1;						// Compare at TOP
	localparam int TCST_PWM = 2;						// PWM compare match

endpackage

`default_nettype wire

//--- design/timer_wave_pkg.sv
`default_nettype none

// ----------------------------------------
// Waveform modes, value selects and events
// ----------------------------------------
package timer_wave_pkg;

	// Code 2'b10 has no mode of its own and runs as normal
	typedef enum logic [1:0] {
		WMOD_NORMAL = 2'b00,							// Free run, pulse on overflow
		WMOD_COMC   = 2'b01,							// Clear at TOP, toggle pin
		WMOD_PWM    = 2'b11								// Pin high below COMPARE
	} wmod_e;

	// Codes not listed here select MAX
	typedef enum logic [3:0] {
		SEL_OCR   = 4'd1,								// Value of OCR
		SEL_BIT08 = 4'd3,								// 0x00FF
		SEL_BIT09 = 4'd4,								// 0x01FF
		SEL_BIT10 = 4'd5,								// 0x03FF
		SEL_BIT11 = 4'd6,								// 0x07FF
		SEL_BIT12 = 4'd7,								// 0x0FFF
		SEL_BIT13 = 4'd8,								// 0x1FFF
		SEL_BIT14 = 4'd9,								// 0x3FFF
		SEL_BIT15 = 4'd10								// 0x7FFF
	} sel_e;

	typedef struct packed {
		logic ovf;										// Wrap from MAX
		logic cmp;										// Clear from TOP
		logic pwm;										// Count reached COMPARE
	} timer_evt_t;

endpackage

`default_nettype wire

//--- design/timer_cfg_if.sv
`timescale 1ns/1ps
`default_nettype none

// Decoded configuration from the register bank to the count pipeline
interface timer_cfg_if #(
	parameter int CNT_W = 16
) ();
	import timer_map_pkg::*;
	import timer_wave_pkg::*;

	logic				cnt_run;						// GEN and CNTEN
	wmod_e				wmod;							// Waveform mode
	logic				pin_en;							// Pin enable
	logic				pin_pol;						// Pin polarity
	logic [PRS_W-1:0]	prs_val;						// Prescale reload value
	logic				prs_ld;							// Prescaler restart
	logic [CNT_W-1:0]	top;							// Decoded TOP
	logic [CNT_W-1:0]	compare;						// Decoded COMPARE
	logic				cnt_ld;							// Counter load
	logic [CNT_W-1:0]	cnt_ld_val;						// Counter load value

	modport regs (
		output cnt_run, wmod, pin_en, pin_pol, prs_val, prs_ld,
		output top, compare, cnt_ld, cnt_ld_val
	);

	modport prs (input cnt_run, prs_val, prs_ld);
	modport cnt (input wmod, top, cnt_ld, cnt_ld_val);
	modport wave (input wmod, pin_en, pin_pol, top, compare);

endinterface

`default_nettype wire

//--- design/timer_regs.sv
`timescale 1ns/1ps
`default_nettype none

module timer_regs #(
	parameter int CNT_W = 16
) (
	input  logic								i_sysclk,		// System clock
	input  logic								i_sysrst,		// Sync reset
	input  logic								i_bus_select,	// Peripheral select
	input  logic								i_bus_wr,		// Write flag
	input  logic [timer_map_pkg::ADDR_W-1:0]	i_reg_addr,		// Register address
	input  logic [CNT_W-1:0]					i_bus_data,		// Write data
	output logic [CNT_W-1:0]					o_bus_data,		// Read data
	output logic								o_bus_ack,		// Acknowledge
	output logic								o_int_flg,		// Interrupt
	input  logic [CNT_W-1:0]					i_count,		// Live count
	input  timer_wave_pkg::timer_evt_t			i_evt,			// Waveform events
	timer_cfg_if.regs							cfg				// Decoded config
);
	import timer_map_pkg::*;
	import timer_wave_pkg::*;

	logic [CNT_W-1:0]	tccr;
	logic [CNT_W-1:0]	tccr2;
	logic [CNT_W-1:0]	ocr;
	logic [2:0]			tcst;							// Only three status bits
	logic [CNT_W-1:0]	top_q;
	logic [CNT_W-1:0]	cmp_q;
	logic [CNT_W-1:0]	rd_q;
	logic				ack_q;
	logic				addr_ok;
	logic				acc_stb;
	logic				wr_stb;
	logic				rd_stb;

	// ----------------------------------------
	// Bus handshake
	// ----------------------------------------
	assign addr_ok = (i_reg_addr == ADDR_TCCR) || (i_reg_addr == ADDR_TCCR2)
		|| (i_reg_addr == ADDR_TCNT) || (i_reg_addr == ADDR_OCR)
		|| (i_reg_addr == ADDR_TCST);
	assign acc_stb = i_bus_select && !ack_q && addr_ok;	// Select rising phase
	assign wr_stb  = acc_stb && i_bus_wr;
	assign rd_stb  = acc_stb && !i_bus_wr;

	always_ff @(posedge i_sysclk)
	begin
		if (i_sysrst)
			ack_q <= 1'b0;
		else if (ack_q)
			ack_q <= i_bus_select;						// Hold until select drops
		else
			ack_q <= acc_stb;
	end

	always_ff @(posedge i_sysclk)
	begin
		if (rd_stb)
		begin
			case (i_reg_addr)
				ADDR_TCCR:  rd_q <= tccr;
				ADDR_TCCR2: rd_q <= tccr2;
				ADDR_TCNT:  rd_q <= i_count;			// Sampled at the ack edge
				ADDR_OCR:   rd_q <= ocr;
				default:    rd_q <= CNT_W'(tcst);
			endcase
		end
	end

	assign o_bus_ack  = ack_q;
	assign o_bus_data = ack_q ? rd_q : '0;				// Quiet bus between reads

	// ----------------------------------------
	// Register bank
	// ----------------------------------------
	always_ff @(posedge i_sysclk)
	begin
		if (i_sysrst)
		begin
			tccr  <= '0;
			tccr2 <= '0;
			ocr   <= '0;
		end
		else if (wr_stb)
		begin
			case (i_reg_addr)
				ADDR_TCCR:  tccr  <= i_bus_data;
				ADDR_TCCR2: tccr2 <= i_bus_data;
				ADDR_OCR:   ocr   <= i_bus_data;
				default:    ;							// TCNT goes to the counter
			endcase
		end
	end

	// Status: bus write wins over a set in the same cycle
	always_ff @(posedge i_sysclk)
	begin
		if (i_sysrst)
			tcst <= '0;
		else if (wr_stb && (i_reg_addr == ADDR_TCST))
			tcst <= i_bus_data[2:0];
		else
		begin
			if (tccr[TCCR_GIE] && tccr[TCCR_OVIE] && i_evt.ovf)
				tcst[TCST_OVF] <= 1'b1;
			if (tccr[TCCR_GIE] && tccr[TCCR_CMIE] && i_evt.cmp)
				tcst[TCST_CMP] <= 1'b1;
			if (tccr[TCCR_GIE] && tccr[TCCR_PWIE] && i_evt.pwm)
				tcst[TCST_PWM] <= 1'b1;
		end
	end

	assign o_int_flg = |tcst;

	// ----------------------------------------
	// TOP / COMPARE decode
	// ----------------------------------------
	function automatic logic [CNT_W-1:0] sel_decode(
		input logic [SEL_W-1:0]	sel,
		input logic [CNT_W-1:0]	ocr_v
	);
		logic [CNT_W-1:0] ones;
		ones = '1;
		case (sel_e'(sel))
			SEL_OCR:
				sel_decode = ocr_v;
			SEL_BIT08, SEL_BIT09, SEL_BIT10, SEL_BIT11,
			SEL_BIT12, SEL_BIT13, SEL_BIT14, SEL_BIT15:
				sel_decode = ones >> (CNT_W - 5 - int'(sel));	// Code 3 is 8 bits wide
			default:
				sel_decode = ones;						// MAX
		endcase
	endfunction

	always_ff @(posedge i_sysclk)
	begin
		if (i_sysrst)
		begin
			top_q <= '1;
			cmp_q <= '1;
		end
		else
		begin
			top_q <= sel_decode(tccr2[TCCR2_TOPSEL +: SEL_W], ocr);
			cmp_q <= sel_decode(tccr2[TCCR2_CMPSEL +: SEL_W], ocr);
		end
	end

	// ----------------------------------------
	// Config out to the stages
	// ----------------------------------------
	always_comb
	begin
		case (tccr[TCCR_WMOD_LSB +: 2])
			WMOD_COMC: cfg.wmod = WMOD_COMC;
			WMOD_PWM:  cfg.wmod = WMOD_PWM;
			default:   cfg.wmod = WMOD_NORMAL;			// 2'b10 too
		endcase
	end

	assign cfg.cnt_run    = tccr[TCCR_GEN] && tccr[TCCR_CNTEN];
	assign cfg.pin_en     = tccr[TCCR_PINEN];
	assign cfg.pin_pol    = tccr[TCCR_PINPOL];
	assign cfg.prs_ld     = wr_stb && (i_reg_addr == ADDR_TCCR2);
	assign cfg.prs_val    = cfg.prs_ld ? i_bus_data[TCCR2_PRS +: PRS_W]	// New value on load
		: tccr2[TCCR2_PRS +: PRS_W];
	assign cfg.cnt_ld     = wr_stb && (i_reg_addr == ADDR_TCNT);
	assign cfg.cnt_ld_val = i_bus_data;
	assign cfg.top        = top_q;
	assign cfg.compare    = cmp_q;

	a_ack_needs_sel: assert property (@(posedge i_sysclk) disable iff (i_sysrst)
		$rose(o_bus_ack) |-> $past(i_bus_select));

endmodule

`default_nettype wire

//--- design/timer_prescaler.sv
`timescale 1ns/1ps
`default_nettype none

module timer_prescaler (
	input  logic		i_sysclk,						// System clock
	input  logic		i_sysrst,						// Sync reset
	timer_cfg_if.prs	cfg,							// Run and reload
	output logic		o_tick							// Count tick
);
	import timer_map_pkg::*;

	logic [PRS_W-1:0] div_cnt;							// Down-counter

	// Reload on bus load or when the division is done
	always_ff @(posedge i_sysclk)
	begin
		if (i_sysrst)
			div_cnt <= '0;
		else if (cfg.prs_ld)
			div_cnt <= cfg.prs_val;						// Restart division
		else if (cfg.cnt_run)
		begin
			if (div_cnt == '0)
				div_cnt <= cfg.prs_val;
			else
				div_cnt <= div_cnt - 1'b1;
		end
	end

	assign o_tick = cfg.cnt_run && !cfg.prs_ld && (div_cnt == '0);	// One per prs_val+1

	// Reload holds off the next tick for prs_val cycles
	a_tick_spacing: assert property (@(posedge i_sysclk) disable iff (i_sysrst)
		o_tick && (cfg.prs_val != '0) |=> !o_tick);

endmodule

`default_nettype wire

//--- design/timer_counter.sv
`timescale 1ns/1ps
`default_nettype none

module timer_counter #(
	parameter int CNT_W = 16
) (
	input  logic				i_sysclk,				// System clock
	input  logic				i_sysrst,				// Sync reset
	timer_cfg_if.cnt			cfg,					// Mode, TOP, load
	input  logic				i_tick,					// From prescaler
	output logic [CNT_W-1:0]	o_count,				// Count value
	output logic				o_tick_d				// Tick, one cycle late
);
	import timer_wave_pkg::*;

	logic clr_mode;										// Modes that clear at TOP
	logic at_top;

	assign clr_mode = (cfg.wmod == WMOD_COMC) || (cfg.wmod == WMOD_PWM);
	assign at_top   = (o_count == cfg.top);

	always_ff @(posedge i_sysclk)
	begin
		if (i_sysrst)
		begin
			o_count  <= '0;
			o_tick_d <= 1'b0;
		end
		else
		begin
			o_tick_d <= i_tick;							// Marks a fresh count
			if (cfg.cnt_ld)
				o_count <= cfg.cnt_ld_val;				// Bus load first
			else if (i_tick)
			begin
				if (clr_mode && at_top)
					o_count <= '0;
				else
					o_count <= o_count + 1'b1;			// Wraps at MAX
			end
		end
	end

endmodule

`default_nettype wire

//--- design/timer_waveform.sv
`timescale 1ns/1ps
`default_nettype none

module timer_waveform #(
	parameter int CNT_W = 16
) (
	input  logic						i_sysclk,		// System clock
	input  logic						i_sysrst,		// Sync reset
	timer_cfg_if.wave					cfg,			// Mode and pin setup
	input  logic [CNT_W-1:0]			i_count,		// Count value
	input  logic						i_tick_d,		// Count just updated
	output timer_wave_pkg::timer_evt_t	o_evt,			// Event pulses
	output logic						o_out_pin		// Output pin
);
	import timer_wave_pkg::*;

	localparam logic [CNT_W-1:0] MAX_VAL = '1;

	logic [CNT_W-1:0]	last_cnt;						// Count one cycle back
	logic				clr_mode;
	logic				wrap_top;
	logic				wrap_max;
	logic				hit_cmp;
	timer_evt_t			evt_nxt;
	logic				pin_q;

	always_ff @(posedge i_sysclk)
	begin
		last_cnt <= i_count;							// Value before the update
	end

	// ----------------------------------------
	// Event detect
	// ----------------------------------------
	assign clr_mode = (cfg.wmod == WMOD_COMC) || (cfg.wmod == WMOD_PWM);
	assign wrap_top = i_tick_d && clr_mode && (i_count == '0) && (last_cnt == cfg.top);
	assign wrap_max = i_tick_d && (i_count == '0) && (last_cnt == MAX_VAL);
	assign hit_cmp  = i_tick_d && (cfg.wmod == WMOD_PWM) && (i_count == cfg.compare)
		&& (last_cnt != cfg.compare);

	// A clear at TOP counts as compare only, even when TOP is MAX or COMPARE is zero
	assign evt_nxt.cmp = wrap_top;
	assign evt_nxt.ovf = wrap_max && !wrap_top;
	assign evt_nxt.pwm = hit_cmp && !wrap_top;

	always_ff @(posedge i_sysclk)
	begin
		if (i_sysrst)
			o_evt <= '0;
		else
			o_evt <= evt_nxt;
	end

	// ----------------------------------------
	// Pin register
	// ----------------------------------------
	always_ff @(posedge i_sysclk)
	begin
		if (i_sysrst)
			pin_q <= 1'b0;
		else if (!cfg.pin_en)
			pin_q <= 1'b0;								// Parked while disabled
		else
		begin
			case (cfg.wmod)
				WMOD_COMC:
				begin
					if (evt_nxt.cmp)
						pin_q <= !pin_q;				// Toggle at TOP
				end
				WMOD_PWM:
					pin_q <= (i_count < cfg.compare);	// Duty set by COMPARE
				default:
					pin_q <= evt_nxt.ovf;				// One-cycle pulse
			endcase
		end
	end

	assign o_out_pin = (pin_q && cfg.pin_en) ^ cfg.pin_pol;

	// Only ovf and pwm may coincide
	a_evt_excl: assert property (@(posedge i_sysclk) disable iff (i_sysrst)
		$onehot0({o_evt.ovf, o_evt.cmp}) && $onehot0({o_evt.cmp, o_evt.pwm}));

endmodule

`default_nettype wire

//--- design/timer_top.sv
`timescale 1ns/1ps
`default_nettype none

module timer_top #(
	parameter int CNT_W = 16							// 16 to 32
) (
	input  logic								i_sysclk,		// System clock
	input  logic								i_sysrst,		// Sync reset
	input  logic								i_bus_select,	// Peripheral select
	input  logic								i_bus_wr,		// Write flag
	input  logic [timer_map_pkg::ADDR_W-1:0]	i_reg_addr,		// Register address
	input  logic [CNT_W-1:0]					i_bus_data,		// Write data
	output logic [CNT_W-1:0]					o_bus_data,		// Read data
	output logic								o_bus_ack,		// Acknowledge
	output logic								o_int_flg,		// Interrupt
	output logic								o_out_pin		// Waveform pin
);
	import timer_wave_pkg::*;

	logic				tick;							// Prescaler to counter
	logic [CNT_W-1:0]	count;
	logic				tick_d;
	timer_evt_t			evt;							// Waveform to status

	timer_cfg_if #(.CNT_W(CNT_W)) u_cfg ();

	// ----------------------------------------
	// Register bank and count pipeline
	// ----------------------------------------
	timer_regs #(.CNT_W(CNT_W)) u_regs (
		.i_sysclk		(i_sysclk),
		.i_sysrst		(i_sysrst),
		.i_bus_select	(i_bus_select),
		.i_bus_wr		(i_bus_wr),
		.i_reg_addr		(i_reg_addr),
		.i_bus_data		(i_bus_data),
		.o_bus_data		(o_bus_data),
		.o_bus_ack		(o_bus_ack),
		.o_int_flg		(o_int_flg),
		.i_count		(count),
		.i_evt			(evt),
		.cfg			(u_cfg.regs)
	);

	timer_prescaler u_prs (
		.i_sysclk		(i_sysclk),
		.i_sysrst		(i_sysrst),
		.cfg			(u_cfg.prs),
		.o_tick			(tick)
	);

	timer_counter #(.CNT_W(CNT_W)) u_cnt (
		.i_sysclk		(i_sysclk),
		.i_sysrst		(i_sysrst),
		.cfg			(u_cfg.cnt),
		.i_tick			(tick),
		.o_count		(count),
		.o_tick_d		(tick_d)
	);

	timer_waveform #(.CNT_W(CNT_W)) u_wave (
		.i_sysclk		(i_sysclk),
		.i_sysrst		(i_sysrst),
		.cfg			(u_cfg.wave),
		.i_count		(count),
		.i_tick_d		(tick_d),
		.o_evt			(evt),
		.o_out_pin		(o_out_pin)
	);

endmodule

`default_nettype wire

//--- verif/tb_timer.sv
`timescale 1ns/1ps
`default_nettype none

module tb_timer;
	import timer_map_pkg::*;
	import timer_wave_pkg::*;

	localparam int CNT_W      = 16;
	localparam int CLK_PERIOD = 100;					// ns
	localparam int ACK_WAIT   = 8;						// Cycles before giving up on ack
	// Cycle budget per test, summed for the watchdog
	localparam int T1_CYC = 200;
	localparam int T2_CYC = 400;
	localparam int T3_CYC = 300;
	localparam int T4_CYC = 800;
	localparam int T5_CYC = 200;
	localparam int MARGIN = 500;
	localparam int RUN_CYC = T1_CYC + T2_CYC + T3_CYC + T4_CYC + T5_CYC + MARGIN;

	localparam logic [CNT_W-1:0] MAX_CNT  = '1;
	localparam logic [CNT_W-1:0] RUN      = (16'd1 << TCCR_GEN) | (16'd1 << TCCR_CNTEN);
	localparam logic [CNT_W-1:0] GIE      = 16'd1 << TCCR_GIE;
	localparam logic [CNT_W-1:0] OVIE     = 16'd1 << TCCR_OVIE;
	localparam logic [CNT_W-1:0] PIN_EN   = 16'd1 << TCCR_PINEN;
	localparam logic [CNT_W-1:0] PIN_POL  = 16'd1 << TCCR_PINPOL;
	localparam logic [CNT_W-1:0] COMC_MOD = 16'(WMOD_COMC) << TCCR_WMOD_LSB;
	localparam logic [CNT_W-1:0] PWM_MOD  = 16'(WMOD_PWM) << TCCR_WMOD_LSB;

	logic				sysclk;
	logic				sysrst;
	logic				bus_select;
	logic				bus_wr;
	logic [ADDR_W-1:0]	reg_addr;
	logic [CNT_W-1:0]	bus_wdata;
	logic [CNT_W-1:0]	bus_rdata;
	logic				bus_ack;
	logic				int_flg;
	logic				out_pin;

	int				cyc = 0;							// Rising edges since start
	int				err_cnt = 0;
	int				chk_cnt = 0;
	logic [31:0]	rng = 32'hb9d480b0;					// Xorshift state

	timer_top #(.CNT_W(CNT_W)) dut (
		.i_sysclk		(sysclk),
		.i_sysrst		(sysrst),
		.i_bus_select	(bus_select),
		.i_bus_wr		(bus_wr),
		.i_reg_addr		(reg_addr),
		.i_bus_data		(bus_wdata),
		.o_bus_data		(bus_rdata),
		.o_bus_ack		(bus_ack),
		.o_int_flg		(int_flg),
		.o_out_pin		(out_pin)
	);

	always #(CLK_PERIOD/2) sysclk = ~sysclk;

	always @(posedge sysclk)
		cyc <= cyc + 1;

	// Ack drops on the edge after select is seen low
	a_ack_release: assert property (@(posedge sysclk) disable iff (sysrst)
		(bus_ack && !bus_select) |=> !bus_ack)
	else
	begin
		$display("Ack stayed high after select fell");
		err_cnt++;
	end

	// ----------------------------------------
	// Helpers
	// ----------------------------------------
	function automatic logic [CNT_W-1:0] rand16();
		rng = rng ^ (rng << 13);
		rng = rng ^ (rng >> 17);
		rng = rng ^ (rng << 5);
		return rng[CNT_W-1:0];
	endfunction

	task automatic expect_value(input string sig, input logic [31:0] got, input logic [31:0] exp);
		chk_cnt++;
		assert (got == exp)
		else
		begin
			$display("Fail %s: got %h, expected %h", sig, got, exp);
			err_cnt++;
		end
	endtask

	// Four-phase transfer, stamps the cycle of the ack edge
	task automatic bus_access(
		input  logic [ADDR_W-1:0]	addr,
		input  logic				wr,
		input  logic [CNT_W-1:0]	wdata,
		output logic [CNT_W-1:0]	rdata,
		output int					ack_cyc
	);
		int wait_cnt;
		wait_cnt = 0;
		@(posedge sysclk);
		bus_select <= 1'b1;
		bus_wr     <= wr;
		reg_addr   <= addr;
		bus_wdata  <= wdata;
		@(negedge sysclk);
		while (!bus_ack && wait_cnt < ACK_WAIT)
		begin
			@(negedge sysclk);
			wait_cnt++;
		end
		chk_cnt++;
		assert (bus_ack)
		else
		begin
			$display("No ack from address %h", addr);
			err_cnt++;
		end
		rdata   = bus_rdata;							// Valid while ack is high
		ack_cyc = cyc;
		@(posedge sysclk);
		bus_select <= 1'b0;
		bus_wr     <= 1'b0;
		@(negedge sysclk);
		while (bus_ack)
			@(negedge sysclk);							// Master waits for ack low
	endtask

	task automatic write_reg(input logic [ADDR_W-1:0] addr, input logic [CNT_W-1:0] data);
		logic [CNT_W-1:0]	dummy;
		int					stamp;
		bus_access(addr, 1'b1, data, dummy, stamp);
	endtask

	task automatic read_reg(input logic [ADDR_W-1:0] addr, output logic [CNT_W-1:0] data);
		int stamp;
		bus_access(addr, 1'b0, '0, data, stamp);
	endtask

	task automatic check_readback(input logic [ADDR_W-1:0] addr, input string name);
		logic [CNT_W-1:0] wval;
		logic [CNT_W-1:0] rval;
		wval = rand16();
		write_reg(addr, wval);
		read_reg(addr, rval);
		expect_value(name, rval, wval);
	endtask

	// Invalid address must stay unanswered for 4 cycles
	task automatic probe_no_ack(input logic [ADDR_W-1:0] addr);
		@(posedge sysclk);
		bus_select <= 1'b1;
		bus_wr     <= 1'b0;
		reg_addr   <= addr;
		repeat (4)
		begin
			@(negedge sysclk);
			chk_cnt++;
			assert (!bus_ack)
			else
			begin
				$display("Address %h was acknowledged", addr);
				err_cnt++;
			end
		end
		@(posedge sysclk);
		bus_select <= 1'b0;								// Abandon the access
		@(negedge sysclk);
	endtask

	task automatic wait_pin_change(input int limit, output logic changed);
		logic	prev;
		int		n;
		prev    = out_pin;
		n       = 0;
		changed = 1'b0;
		while (!changed && n < limit)
		begin
			@(negedge sysclk);
			changed = (out_pin != prev);
			n++;
		end
	endtask

	task automatic report_test(input int num, input string name, input int err_start);
		$display("Test %0d %s finished with %0d errors", num, name, err_cnt - err_start);
	endtask

	// ----------------------------------------
	// Watchdog
	// ----------------------------------------
	initial
	begin
		#(CLK_PERIOD * RUN_CYC);
		$display("Watchdog expired after %0d cycles", RUN_CYC);
		$display("TESTS FAILED");
		$finish;
	end

	// ----------------------------------------
	// Test sequence
	// ----------------------------------------
	initial
	begin
		logic [CNT_W-1:0]	c1;
		logic [CNT_W-1:0]	c2;
		logic [CNT_W-1:0]	delta;
		logic				changed;
		logic				seen;
		int					t1;
		int					t2;
		int					p;
		int					k;
		int					n;
		int					c;
		int					lo;
		int					hi;
		int					span;
		int					last;
		int					high;
		int					err_start;

		sysclk     = 1'b0;
		sysrst     <= 1'b1;
		bus_select <= 1'b0;
		bus_wr     <= 1'b0;
		reg_addr   <= '0;
		bus_wdata  <= '0;
		repeat (4) @(posedge sysclk);
		sysrst <= 1'b0;

		// Register access
		err_start = err_cnt;
		for (int i = 0; i < 4; i++)
		begin
			check_readback(ADDR_TCCR, "TCCR");
			check_readback(ADDR_TCCR2, "TCCR2");
			check_readback(ADDR_OCR, "OCR");
		end
		probe_no_ack(4'd5);
		probe_no_ack(4'd0);
		write_reg(ADDR_TCCR, '0);
		write_reg(ADDR_TCST, '0);
		report_test(1, "register access", err_start);

		// Prescaled count rate
		err_start = err_cnt;
		for (int i = 0; i < 3; i++)
		begin
			p = int'(rand16() % 8);
			k = 20 + int'(rand16() % 40);
			write_reg(ADDR_TCCR, '0);
			write_reg(ADDR_TCCR2, CNT_W'(p));
			write_reg(ADDR_TCNT, rand16());
			write_reg(ADDR_TCCR, RUN);
			bus_access(ADDR_TCNT, 1'b0, '0, c1, t1);
			repeat (k) @(posedge sysclk);
			bus_access(ADDR_TCNT, 1'b0, '0, c2, t2);
			span  = t2 - t1;
			delta = c2 - c1;							// Modulo arithmetic covers wrap
			lo    = span / (p + 1) - 1;
			hi    = (span + p) / (p + 1) + 1;
			chk_cnt++;
			assert (int'(delta) >= lo && int'(delta) <= hi)
			else
			begin
				$display("Fail TCNT delta: got %h, expected %h to %h", delta, lo, hi);
				err_cnt++;
			end
		end
		report_test(2, "prescaler", err_start);

		// COMC with TOP from OCR
		err_start = err_cnt;
		n = 3 + int'(rand16() % 10);
		write_reg(ADDR_TCCR, '0);
		write_reg(ADDR_OCR, CNT_W'(n));
		write_reg(ADDR_TCCR2, 16'(SEL_OCR) << TCCR2_TOPSEL);
		write_reg(ADDR_TCNT, '0);
		write_reg(ADDR_TCCR, RUN | COMC_MOD | PIN_EN);
		wait_pin_change(4 * (n + 1) + 8, changed);
		chk_cnt++;
		assert (changed)
		else
		begin
			$display("Pin never toggled in COMC mode");
			err_cnt++;
		end
		last = cyc;
		for (int e = 0; e < 4; e++)
		begin
			wait_pin_change(2 * (n + 1), changed);
			expect_value("o_out_pin period", cyc - last, n + 1);
			last = cyc;
		end
		for (int i = 0; i < 5; i++)
		begin
			read_reg(ADDR_TCNT, c1);
			chk_cnt++;
			assert (int'(c1) <= n)
			else
			begin
				$display("Fail TCNT: got %h, expected at most %h", c1, n);
				err_cnt++;
			end
		end
		report_test(3, "COMC toggle", err_start);

		// PWM duty over an 8-bit period
		err_start = err_cnt;
		c = 1 + int'(rand16() % 254);
		for (int pol = 0; pol < 2; pol++)
		begin
			write_reg(ADDR_TCCR, '0);
			write_reg(ADDR_OCR, CNT_W'(c));
			write_reg(ADDR_TCCR2, (16'(SEL_BIT08) << TCCR2_TOPSEL)
				| (16'(SEL_OCR) << TCCR2_CMPSEL));
			write_reg(ADDR_TCNT, '0);
			write_reg(ADDR_TCCR, RUN | PWM_MOD | PIN_EN | (pol != 0 ? PIN_POL : '0));
			repeat (8) @(negedge sysclk);				// Let the pipeline settle
			high = 0;
			repeat (256)
			begin
				@(negedge sysclk);
				if (out_pin)
					high++;
			end
			expect_value("o_out_pin high cycles", high, (pol != 0) ? 256 - c : c);
		end
		report_test(4, "PWM duty", err_start);

		// Overflow interrupt
		err_start = err_cnt;
		write_reg(ADDR_TCCR, '0);
		write_reg(ADDR_TCST, '0);
		write_reg(ADDR_TCCR2, '0);
		write_reg(ADDR_TCNT, MAX_CNT - 16'd3);
		write_reg(ADDR_TCCR, RUN | GIE | OVIE);
		seen = 1'b0;
		for (int i = 0; i < 10 && !seen; i++)
		begin
			@(negedge sysclk);
			seen = int_flg;
		end
		expect_value("o_int_flg", seen, 1);
		read_reg(ADDR_TCST, c1);
		expect_value("TCST[0]", c1[TCST_OVF], 1);
		write_reg(ADDR_TCST, '0);
		expect_value("o_int_flg", int_flg, 0);
		write_reg(ADDR_TCCR, '0);
		write_reg(ADDR_TCNT, MAX_CNT - 16'd3);
		write_reg(ADDR_TCCR, RUN | GIE);				// OVIE left clear
		seen = 1'b0;
		repeat (12)
		begin
			@(negedge sysclk);
			seen = seen | int_flg;
		end
		expect_value("o_int_flg", seen, 0);
		report_test(5, "overflow interrupt", err_start);

		$display("Checks run: %0d, errors: %0d", chk_cnt, err_cnt);
		if (err_cnt == 0)
			$display("TESTS PASSED");
		else
			$display("TESTS FAILED");
		$finish;
	end

endmodule

`default_nettype wire

//--- files.f
design/timer_map_pkg.sv
design/timer_wave_pkg.sv
design/timer_cfg_if.sv
design/timer_regs.sv
design/timer_prescaler.sv
design/timer_counter.sv
design/timer_waveform.sv
design/timer_top.sv
verif/tb_timer.sv

//--- run_sim.sh
#!/bin/sh
# Build the testbench with Verilator, run it, then scan the log
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -Wno-fatal --top-module tb_timer \
	-f files.f -Mdir obj_dir -o sim_tb_timer > build.log 2>&1 &&
./obj_dir/sim_tb_timer > sim.log 2>&1 ||
{ cat build.log; echo "Build or run of the simulation failed"; exit 1; }
cat sim.log
grep -q "TESTS FAILED" sim.log && exit 1 || exit 0
